// File: Makefile
TOP := tlbTb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard src/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: compile.f
src/tlbOpPkg.sv
src/tlbEntryPkg.sv
src/tlbRequestStage.sv
src/tlbWay.sv
src/tlbResolve.sv
src/mmuTlb.sv
verif/tlbTb.sv

// File: src/mmuTlb.sv
// Four-way TLB between a virtual-address L1 and a physical-address L2.
// Two-stage pipeline, stalled as a whole by hold.
`timescale 1ns/1ns

module mmuTlb #(
	parameter int numWays = 4,
	parameter int setBits = 6
) (
	input logic clock,
	input logic rstN,
	input logic hold,
	input tlbOpPkg::tlbOp_t reqOp,
	input tlbOpPkg::vaddr_t reqAddr,
	input tlbOpPkg::seqTag_t reqTag,
	input tlbEntryPkg::tlbEntry_t ldEntry,
	input logic mmuEnable,
	input tlbEntryPkg::asid_t asid,
	output tlbOpPkg::vaddr_t respAddr,
	output tlbOpPkg::tlbOp_t respOp,
	output tlbOpPkg::seqTag_t respTag,
	output tlbOpPkg::excCode_t respExc,
	output tlbOpPkg::vaddr_t respTea
);
	import tlbOpPkg::*;
	import tlbEntryPkg::*;

	logic [setBits-1:0] readIndex;
	logic [setBits-1:0] curIndex;
	tlbOp_t curOp;
	vaddr_t curAddr;
	seqTag_t curTag;
	logic curMmuEnable;
	asid_t curAsid;
	rover_t rover;
	logic insertEn;
	tlbEntry_t insertEntry;
	logic [numWays-1:0] wayHit;
	tlbEntry_t [numWays-1:0] wayEntry;
	tlbEntry_t [numWays-1:0] wayShiftIn;

	tlbRequestStage #(
		.setBits(setBits)
	) u_req (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.reqOp(reqOp),
		.reqAddr(reqAddr),
		.reqTag(reqTag),
		.ldEntry(ldEntry),
		.mmuEnable(mmuEnable),
		.asid(asid),
		.readIndex(readIndex),
		.curIndex(curIndex),
		.curOp(curOp),
		.curAddr(curAddr),
		.curTag(curTag),
		.curMmuEnable(curMmuEnable),
		.curAsid(curAsid),
		.rover(rover),
		.insertEn(insertEn),
		.insertEntry(insertEntry)
	);

	// new entry enters way 0, each way hands its old entry one way down
	assign wayShiftIn = {wayEntry[numWays-2:0], insertEntry};

	for (genvar i = 0; i < numWays; i++)
	begin : g_way
		tlbWay #(
			.setBits(setBits)
		) u_way (
			.clock(clock),
			.hold(hold),
			.readIndex(readIndex),
			.curIndex(curIndex),
			.curAddr(curAddr),
			.curAsid(curAsid),
			.rover(rover),
			.insertEn(insertEn),
			.shiftIn(wayShiftIn[i]),
			.entryOut(wayEntry[i]),
			.hit(wayHit[i])
		);
	end

	tlbResolve #(
		.numWays(numWays)
	) u_resolve (
		.clock(clock),
		.rstN(rstN),
		.hold(hold),
		.curOp(curOp),
		.curAddr(curAddr),
		.curTag(curTag),
		.curMmuEnable(curMmuEnable),
		.wayHit(wayHit),
		.wayEntry(wayEntry),
		.respAddr(respAddr),
		.respOp(respOp),
		.respTag(respTag),
		.respExc(respExc),
		.respTea(respTea)
	);

endmodule

// File: src/tlbEntryPkg.sv
// Entry layout and page geometry of the TLB.
// The ways store tlbEntry_t; LDTLB supplies one on ldEntry.
package tlbEntryPkg;

	// 4 KiB pages only
	localparam int pageShift = 12;

	// 48-bit address minus the page offset
	localparam int vpnBits = 48 - pageShift;

	typedef logic [15:0] asid_t;
	typedef logic [7:0] rover_t;
	typedef logic [vpnBits-1:0] vpn_t;
	typedef logic [vpnBits-1:0] ppn_t;

	// one translation
	// an entry only counts while its rover matches the live generation
	typedef struct packed {
		logic valid;
		rover_t rover;
		asid_t asid;
		vpn_t vpn;
		ppn_t ppn;
	} tlbEntry_t;

endpackage

// File: src/tlbOpPkg.sv
// Request-side definitions for the TLB: operation codes, address and tag types,
// exception codes and the fixed physical-window constants.
package tlbOpPkg;

	// virtual and physical addresses share one width
	localparam int vaBits = 48;

	typedef logic [7:0] tlbOp_t;
	typedef logic [vaBits-1:0] vaddr_t;
	typedef logic [15:0] seqTag_t;
	typedef logic [15:0] excCode_t;

	// operation codes carried on reqOp
	localparam tlbOp_t opIdle = 8'h00;
	localparam tlbOp_t opLoad = 8'h91;
	localparam tlbOp_t opStore = 8'hA1;
	localparam tlbOp_t opLdtlb = 8'h0C;
	localparam tlbOp_t opInvtlb = 8'h0D;

	// raised on a translated access with no matching entry
	localparam excCode_t excMiss = 16'hA001;

	// top nibble of an untranslated physical address
	localparam logic [3:0] physWindow = 4'hC;

	// page number a missing access is redirected to
	localparam logic [31:0] faultPage = 32'h0000_0010;

endpackage

// File: src/tlbRequestStage.sv
// First pipeline stage of the TLB. Registers the incoming request, forms the
// set index for the way arrays and keeps the generation counter.
`timescale 1ns/1ns

module tlbRequestStage #(
	parameter int setBits = 6
) (
	input logic clock,
	input logic rstN,
	input logic hold,
	input tlbOpPkg::tlbOp_t reqOp,
	input tlbOpPkg::vaddr_t reqAddr,
	input tlbOpPkg::seqTag_t reqTag,
	input tlbEntryPkg::tlbEntry_t ldEntry,
	input logic mmuEnable,
	input tlbEntryPkg::asid_t asid,
	output logic [setBits-1:0] readIndex,
	output logic [setBits-1:0] curIndex,
	output tlbOpPkg::tlbOp_t curOp,
	output tlbOpPkg::vaddr_t curAddr,
	output tlbOpPkg::seqTag_t curTag,
	output logic curMmuEnable,
	output tlbEntryPkg::asid_t curAsid,
	output tlbEntryPkg::rover_t rover,
	output logic insertEn,
	output tlbEntryPkg::tlbEntry_t insertEntry
);
	import tlbOpPkg::*;
	import tlbEntryPkg::*;

	tlbEntry_t curEntry;
	vpn_t reqVpn;

	// LDTLB indexes by the vpn of the new entry, everything else by the address
	assign reqVpn = (reqOp == opLdtlb) ? ldEntry.vpn : reqAddr[vaBits-1:pageShift];
	assign readIndex = reqVpn[setBits-1:0];

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			curOp <= opIdle;
			curMmuEnable <= 1'b0;
			rover <= '0;
		end
		else if (!hold)
		begin
			curOp <= reqOp;
			curMmuEnable <= mmuEnable;
			// invalidate everything by moving to a new generation
			if (curOp == opInvtlb)
				rover <= rover + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			curAddr <= reqAddr;
			curTag <= reqTag;
			curAsid <= asid;
			curIndex <= readIndex;
			curEntry <= ldEntry;
		end
	end

	assign insertEn = (curOp == opLdtlb);

	// new entry is stamped with the live generation
	always_comb
	begin
		insertEntry = curEntry;
		insertEntry.valid = 1'b1;
		insertEntry.rover = rover;
	end

	// a registered LDTLB can only appear through an edge that was not held
	insertNotHeld: assert property (@(posedge clock) disable iff (!rstN)
		$rose(insertEn) |-> !$past(hold));

endmodule

// File: src/tlbResolve.sv
// Second pipeline stage of the TLB. Picks the hitting way, decides between
// bypass, translation and miss, and registers the response toward the L2.
`timescale 1ns/1ns

module tlbResolve #(
	parameter int numWays = 4
) (
	input logic clock,
	input logic rstN,
	input logic hold,
	input tlbOpPkg::tlbOp_t curOp,
	input tlbOpPkg::vaddr_t curAddr,
	input tlbOpPkg::seqTag_t curTag,
	input logic curMmuEnable,
	input logic [numWays-1:0] wayHit,
	input tlbEntryPkg::tlbEntry_t [numWays-1:0] wayEntry,
	output tlbOpPkg::vaddr_t respAddr,
	output tlbOpPkg::tlbOp_t respOp,
	output tlbOpPkg::seqTag_t respTag,
	output tlbOpPkg::excCode_t respExc,
	output tlbOpPkg::vaddr_t respTea
);
	import tlbOpPkg::*;
	import tlbEntryPkg::*;

	logic isAccess;
	logic inPhysWindow;
	logic bypass;
	ppn_t selPpn;
	vaddr_t nxtAddr;
	excCode_t nxtExc;
	vaddr_t nxtTea;

	assign isAccess = (curOp == opLoad) || (curOp == opStore);
	assign inPhysWindow = (curAddr[vaBits-1 -: 4] == physWindow);
	assign bypass = !curMmuEnable || inPhysWindow || !isAccess;

	// lowest hitting way wins
	always_comb
	begin
		selPpn = '0;
		for (int i = numWays - 1; i >= 0; i--)
		begin
			if (wayHit[i])
				selPpn = wayEntry[i].ppn;
		end
	end

	always_comb
	begin
		nxtAddr = curAddr;
		nxtExc = '0;
		nxtTea = '0;
		if (!bypass)
		begin
			if (|wayHit)
			begin
				nxtAddr = {selPpn, curAddr[pageShift-1:0]};
			end
			else
			begin
				// redirect into the fault page and report the faulting address
				nxtAddr = {physWindow, faultPage, curAddr[pageShift-1:0]};
				nxtExc = excMiss;
				nxtTea = curAddr;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			respOp <= opIdle;
			respExc <= '0;
		end
		else if (!hold)
		begin
			respOp <= curOp;
			respExc <= nxtExc;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			respAddr <= nxtAddr;
			respTag <= curTag;
			respTea <= nxtTea;
		end
	end

	// LDTLB must never leave the same translation in two ways of a set
	oneWayHit: assert property (@(posedge clock) disable iff (!rstN)
		(!hold && isAccess && curMmuEnable) |-> $onehot0(wayHit));

endmodule

// File: src/tlbWay.sv
// One way of the set-associative TLB: entry array with registered read,
// tag compare against the registered request, and the LDTLB shift write.
`timescale 1ns/1ns

module tlbWay #(
	parameter int setBits = 6
) (
	input logic clock,
	input logic hold,
	input logic [setBits-1:0] readIndex,
	input logic [setBits-1:0] curIndex,
	input tlbOpPkg::vaddr_t curAddr,
	input tlbEntryPkg::asid_t curAsid,
	input tlbEntryPkg::rover_t rover,
	input logic insertEn,
	input tlbEntryPkg::tlbEntry_t shiftIn,
	output tlbEntryPkg::tlbEntry_t entryOut,
	output logic hit
);
	import tlbOpPkg::*;
	import tlbEntryPkg::*;

	tlbEntry_t entries [2**setBits];

	// start with every entry invalid
	initial
	begin
		for (int i = 0; i < 2**setBits; i++)
			entries[i] = '0;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			// forward a write to the same set so back-to-back LDTLBs chain correctly
			if (insertEn && (curIndex == readIndex))
				entryOut <= shiftIn;
			else
				entryOut <= entries[readIndex];
			if (insertEn)
				entries[curIndex] <= shiftIn;
		end
	end

	// stale generations never match
	assign hit = entryOut.valid &&
		(entryOut.rover == rover) &&
		(entryOut.asid == curAsid) &&
		(entryOut.vpn == curAddr[vaBits-1:pageShift]);

endmodule

// File: verif/tlbTb.sv
// Self-checking testbench for mmuTlb. Drives lookups, LDTLB and INVTLB requests
// and checks every response through concurrent assertions on an expected pipeline.
`timescale 1ns/1ns

module tlbTb;
	import tlbOpPkg::*;
	import tlbEntryPkg::*;

	// well above the roughly 70 cycles the tests take
	localparam int maxCycles = 2000;

	typedef struct packed {
		logic live;
		logic check;
		tlbOp_t op;
		seqTag_t tag;
		vaddr_t addr;
		excCode_t exc;
		vaddr_t tea;
	} expected_t;

	logic clock;
	logic rstN;
	logic hold;
	tlbOp_t reqOp;
	vaddr_t reqAddr;
	seqTag_t reqTag;
	tlbEntry_t ldEntry;
	logic mmuEnable;
	asid_t asid;
	vaddr_t respAddr;
	tlbOp_t respOp;
	seqTag_t respTag;
	excCode_t respExc;
	vaddr_t respTea;

	expected_t expNext;
	expected_t expMid;
	expected_t expOut;
	logic [31:0] lcgState;
	int errorCount = 0;
	int failedTests = 0;
	int testCount = 0;
	int errorsAtStart = 0;
	int cycleCount = 0;
	vpn_t vpnList [5];
	ppn_t ppnList [5];

	mmuTlb #(.numWays(4), .setBits(6)) u_dut (.*);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount >= maxCycles)
		begin
			$display("timeout: run did not finish within %0d cycles", maxCycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// two-deep latency model that advances only on edges without hold
	always @(posedge clock)
	begin
		if (!rstN)
		begin
			expMid <= '0;
			expOut <= '0;
		end
		else if (!hold)
		begin
			expMid <= expNext;
			expOut <= expMid;
		end
	end

	function automatic void reportMismatch(input string name, input logic [47:0] got,
		input logic [47:0] want);
		errorCount++;
		$display("[ERROR] %s got %h expected %h", name, got, want);
	endfunction

	function automatic void reportFailure(input string what);
		errorCount++;
		$display("%s", what);
	endfunction

	opCheck: assert property (@(posedge clock) disable iff (!rstN)
		expOut.live |-> respOp == expOut.op)
		else reportMismatch("respOp", 48'($sampled(respOp)), 48'($sampled(expOut.op)));
	tagCheck: assert property (@(posedge clock) disable iff (!rstN)
		expOut.live |-> respTag == expOut.tag)
		else reportMismatch("respTag", 48'($sampled(respTag)), 48'($sampled(expOut.tag)));
	addrCheck: assert property (@(posedge clock) disable iff (!rstN)
		expOut.check |-> respAddr == expOut.addr)
		else reportMismatch("respAddr", $sampled(respAddr), $sampled(expOut.addr));
	excCheck: assert property (@(posedge clock) disable iff (!rstN)
		expOut.check |-> respExc == expOut.exc)
		else reportMismatch("respExc", 48'($sampled(respExc)), 48'($sampled(expOut.exc)));
	teaCheck: assert property (@(posedge clock) disable iff (!rstN)
		expOut.check |-> respTea == expOut.tea)
		else reportMismatch("respTea", $sampled(respTea), $sampled(expOut.tea));
	holdCheck: assert property (@(posedge clock) disable iff (!rstN)
		hold |=> $stable(respAddr) && $stable(respOp) && $stable(respTag)
			&& $stable(respExc) && $stable(respTea))
		else reportFailure("outputs changed while hold was high");

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic vaddr_t randomAddr();
		logic [31:0] high;
		high = nextRand();
		return {high[15:0], nextRand()};
	endfunction

	task automatic tick();
		@(posedge clock);
		#1;
	endtask

	// every request gets a fresh tag so a late or early result shows up
	task automatic send(input tlbOp_t op, input vaddr_t addr, input logic check,
		input vaddr_t wantAddr, input excCode_t wantExc, input vaddr_t wantTea);
		tick();
		reqOp = op;
		reqAddr = addr;
		reqTag = reqTag + 16'h1;
		expNext = '{live: 1'b1, check: check, op: op, tag: reqTag,
			addr: wantAddr, exc: wantExc, tea: wantTea};
	endtask

	task automatic idle();
		send(opIdle, '0, 1'b0, '0, '0, '0);
	endtask

	task automatic expectPass(input tlbOp_t op, input vaddr_t addr);
		send(op, addr, 1'b1, addr, 16'h0000, '0);
	endtask

	task automatic expectHit(input vaddr_t addr, input ppn_t ppn);
		send(opLoad, addr, 1'b1, {ppn, addr[11:0]}, 16'h0000, '0);
	endtask

	// redirect into fault page 010 of the C window keeping the page offset
	task automatic expectMiss(input vaddr_t addr);
		send(opStore, addr, 1'b1, {4'hC, 32'h0000_0010, addr[11:0]}, 16'hA001, addr);
	endtask

	task automatic loadEntry(input vpn_t vpn, input ppn_t ppn, input asid_t entryAsid);
		send(opLdtlb, {vpn, 12'h000}, 1'b0, '0, '0, '0);
		ldEntry = '{valid: 1'b0, rover: '0, asid: entryAsid, vpn: vpn, ppn: ppn};
	endtask

	task automatic holdFor(input int cycles);
		hold = 1'b1;
		repeat (cycles)
			tick();
		hold = 1'b0;
	endtask

	task automatic startTest();
		errorsAtStart = errorCount;
	endtask

	// three idles let the last result reach its check before the verdict
	task automatic finishTest(input string name);
		idle();
		idle();
		idle();
		testCount++;
		if (errorCount != errorsAtStart)
			failedTests++;
		$display("test %0d %s: %s", testCount, name,
			(errorCount == errorsAtStart) ? "ok" : "FAILED");
	endtask

	initial
	begin
		vaddr_t addr;
		logic [31:0] rnd;
		rstN = 1'b0;
		hold = 1'b0;
		reqOp = opIdle;
		reqAddr = '0;
		reqTag = '0;
		ldEntry = '0;
		mmuEnable = 1'b0;
		asid = 16'h0042;
		expNext = '0;
		lcgState = 32'h836c;
		repeat (2)
			@(posedge clock);
		#1;
		rstN = 1'b1;

		startTest();
		for (int i = 0; i < 8; i++)
			expectPass(opLoad, randomAddr());
		finishTest("mmu disabled");

		mmuEnable = 1'b1;
		startTest();
		for (int i = 0; i < 6; i++)
		begin
			addr = randomAddr();
			expectPass((i % 2) ? opStore : opLoad, {4'hC, addr[43:0]});
		end
		finishTest("physical window");

		startTest();
		for (int i = 0; i < 4; i++)
		begin
			vpnList[i] = {4'h1, nextRand()};
			ppnList[i] = {4'h0, nextRand()};
			loadEntry(vpnList[i], ppnList[i], 16'h0042);
		end
		idle();
		for (int i = 0; i < 4; i++)
		begin
			rnd = nextRand();
			expectHit({vpnList[i], rnd[11:0]}, ppnList[i]);
		end
		finishTest("translated hit");

		startTest();
		rnd = nextRand();
		expectMiss({4'h2, nextRand(), rnd[11:0]});
		// known vpn, but this lookup runs under another ASID
		expectMiss({vpnList[0], 12'h345});
		asid = 16'h0043;
		finishTest("miss");

		asid = 16'h0042;
		startTest();
		expectHit({vpnList[1], 12'h123}, ppnList[1]);
		send(opInvtlb, '0, 1'b0, '0, '0, '0);
		idle();
		for (int i = 0; i < 4; i++)
			expectMiss({vpnList[i], 12'h123});
		finishTest("invalidation");

		startTest();
		// low vpn byte shared so all five land in one set
		for (int i = 0; i < 5; i++)
		begin
			vpnList[i] = {4'h3, 14'h0, 10'(i), 8'hA5};
			ppnList[i] = {4'h0, nextRand()};
			loadEntry(vpnList[i], ppnList[i], 16'h0042);
		end
		idle();
		expectMiss({vpnList[0], 12'h0F0});
		for (int i = 1; i < 5; i++)
			expectHit({vpnList[i], 12'h0F0 + 12'(i)}, ppnList[i]);
		holdFor(3);
		expectHit({vpnList[4], 12'hABC}, ppnList[4]);
		finishTest("eviction and hold");

		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
